/* hdl/cam_bist_macros.svh */
// CAM geometry and BIST pattern macros, included by the package and by RTL that needs the sizes
`ifndef CAM_BIST_MACROS_SVH
`define CAM_BIST_MACROS_SVH

// ----------------------------------------
// Array geometry
// ----------------------------------------

// Entry and search key width
`define CAM_DWIDTH 16

// Number of CAM entries
`define CAM_DEPTH 8

// Entry index width, log2 of the depth
`define CAM_AWIDTH 3

// Base BIST data, inverted in the second pass
`define CAM_BIST_PATTERN 16'hA5C3

`endif

/* hdl/cam_bist_pkg.sv */
// Shared CAM BIST types, referenced by scoped name from every RTL block
`include "cam_bist_macros.svh"

package cam_bist_pkg;

   // ----------------------------------------
   // Vector types
   // ----------------------------------------

   // One key or one stored entry
   typedef logic [`CAM_DWIDTH-1:0] cam_data_t;
   // Entry index
   typedef logic [`CAM_AWIDTH-1:0] cam_addr_t;
   // Bit n set when entry n matched
   typedef logic [`CAM_DEPTH-1:0]  cam_match_t;

   // ----------------------------------------
   // Bundles
   // ----------------------------------------

   // One operation on the shared CAM port
   typedef struct packed {
      logic      valid;
      logic      write;
      cam_addr_t addr;
      cam_data_t data;
   } cam_op_t;

   // Host request payload, held stable while host_req is high
   typedef struct packed {
      logic      write;
      cam_addr_t addr;
      cam_data_t data;
   } host_req_t;

   // Expected search outcome for a BIST op
   typedef enum logic [1:0] {
      EXP_NONE,
      EXP_ALL,
      EXP_NONE_MATCH
   } expect_t;

   // BIST sequencer states
   typedef enum logic [2:0] {
      IDLE,
      WRITE,
      SEARCH_FULL,
      SEARCH_MASK,
      WAIT,
      DONE
   } bist_state_t;

endpackage

/* hdl/cam_bist_inhandler.sv */
// BIST input handler, holds the rotating mask and forms write data and compare keys for the port
`timescale 1ns/1ps
`include "cam_bist_macros.svh"

module cam_bist_inhandler (
   input  logic                  bist_clk,
   input  logic                  rst_b,
   input  logic                  inv_data,
   input  logic                  mask_en,
   input  logic                  rotate,
   input  cam_bist_pkg::cam_op_t seq_op,
   output cam_bist_pkg::cam_op_t bist_op
);

   // One-hot mask
   cam_bist_pkg::cam_data_t mask;
   // Pattern after pass inversion
   cam_bist_pkg::cam_data_t wr_data;
   // Search key with the masked bit flipped
   cam_bist_pkg::cam_data_t cmp_key;

   // ----------------------------------------
   // Rotating mask
   // ----------------------------------------

   // Starts at bit 0, moves left one place per rotate pulse
   // Top bit wraps back to bit 0
   always_ff @(posedge bist_clk) begin
      if (!rst_b) begin
         mask <= cam_bist_pkg::cam_data_t'(1);
      end else if (rotate) begin
         mask <= {mask[`CAM_DWIDTH-2:0], mask[`CAM_DWIDTH-1]};
      end
   end

   // ----------------------------------------
   // Data and key generation
   // ----------------------------------------

   // Whole word flips in the inverted pass
   assign wr_data = `CAM_BIST_PATTERN ^ {`CAM_DWIDTH{inv_data}};

   // Masked search flips exactly one bit so no entry may match
   assign cmp_key = wr_data ^ (mask & {`CAM_DWIDTH{mask_en}});

   // Control fields come straight from the sequencer
   always_comb begin
      bist_op.valid = seq_op.valid;
      bist_op.write = seq_op.write;
      bist_op.addr  = seq_op.addr;
      // Writes store the plain pass data, searches use the key
      bist_op.data  = seq_op.write ? wr_data : cmp_key;
   end

endmodule

/* hdl/cam_bist_sequencer.sv */
// March-style CAM BIST sequencer, runs the true and inverted passes under a four-phase req/ack
`timescale 1ns/1ps
`include "cam_bist_macros.svh"

module cam_bist_sequencer (
   input  logic                  bist_clk,
   input  logic                  rst_b,
   input  logic                  bist_req,
   input  logic                  check_only,
   output logic                  bist_ack,
   output logic                  bist_active,
   output logic                  inv_data,
   output logic                  mask_en,
   output logic                  rotate,
   output cam_bist_pkg::cam_op_t seq_op,
   output cam_bist_pkg::expect_t bist_expect
);

   // Width of the mask position counter
   localparam int BIT_W = $clog2(`CAM_DWIDTH);

   cam_bist_pkg::bist_state_t state;
   // Op state that the current WAIT follows
   cam_bist_pkg::bist_state_t op_state;
   // Second pass uses inverted data
   logic                      pass_inv;
   // Check-only request latched at start
   logic                      chk_only;
   cam_bist_pkg::cam_addr_t   entry;
   // Mask position of the current masked search
   logic [BIT_W-1:0]          bit_cnt;

   // ----------------------------------------
   // State machine
   // ----------------------------------------

   always_ff @(posedge bist_clk) begin
      if (!rst_b) begin
         state    <= cam_bist_pkg::IDLE;
         op_state <= cam_bist_pkg::IDLE;
         pass_inv <= 1'b0;
         chk_only <= 1'b0;
         entry    <= '0;
         bit_cnt  <= '0;
      end else begin
         case (state)
            cam_bist_pkg::IDLE: begin
               if (bist_req) begin
                  chk_only <= check_only;
                  pass_inv <= 1'b0;
                  entry    <= '0;
                  bit_cnt  <= '0;
                  // Retained contents are checked without rewriting
                  state    <= check_only ? cam_bist_pkg::SEARCH_FULL : cam_bist_pkg::WRITE;
               end
            end
            cam_bist_pkg::WRITE,
            cam_bist_pkg::SEARCH_FULL,
            cam_bist_pkg::SEARCH_MASK: begin
               // Every op is followed by one idle cycle
               op_state <= state;
               state    <= cam_bist_pkg::WAIT;
            end
            cam_bist_pkg::WAIT: begin
               case (op_state)
                  cam_bist_pkg::WRITE: begin
                     if (entry == cam_bist_pkg::cam_addr_t'(`CAM_DEPTH-1)) begin
                        entry <= '0;
                        state <= cam_bist_pkg::SEARCH_FULL;
                     end else begin
                        entry <= entry + 1'b1;
                        state <= cam_bist_pkg::WRITE;
                     end
                  end
                  cam_bist_pkg::SEARCH_FULL: begin
                     bit_cnt <= '0;
                     state   <= cam_bist_pkg::SEARCH_MASK;
                  end
                  default: begin
                     // Last mask bit ends the pass, mask has wrapped to bit 0
                     if (bit_cnt == BIT_W'(`CAM_DWIDTH-1)) begin
                        bit_cnt <= '0;
                        if (pass_inv) begin
                           state <= cam_bist_pkg::DONE;
                        end else begin
                           pass_inv <= 1'b1;
                           state    <= chk_only ? cam_bist_pkg::SEARCH_FULL :
                                                  cam_bist_pkg::WRITE;
                        end
                     end else begin
                        bit_cnt <= bit_cnt + 1'b1;
                        state   <= cam_bist_pkg::SEARCH_MASK;
                     end
                  end
               endcase
            end
            cam_bist_pkg::DONE: begin
               // Hold ack until the requester lets go
               if (!bist_req) begin
                  state <= cam_bist_pkg::IDLE;
               end
            end
            default: begin
               state <= cam_bist_pkg::IDLE;
            end
         endcase
      end
   end

   // ----------------------------------------
   // Decoded outputs
   // ----------------------------------------

   assign bist_ack    = (state == cam_bist_pkg::DONE);
   // Busy from the first op state until ack
   assign bist_active = (state != cam_bist_pkg::IDLE) && (state != cam_bist_pkg::DONE);
   assign inv_data    = pass_inv;
   assign mask_en     = (state == cam_bist_pkg::SEARCH_MASK);
   // Advance the mask in the wait slot after each masked search
   assign rotate      = (state == cam_bist_pkg::WAIT) && (op_state == cam_bist_pkg::SEARCH_MASK);

   always_comb begin
      seq_op.valid = (state == cam_bist_pkg::WRITE) || (state == cam_bist_pkg::SEARCH_FULL) ||
                     (state == cam_bist_pkg::SEARCH_MASK);
      seq_op.write = (state == cam_bist_pkg::WRITE);
      seq_op.addr  = entry;
      // Data is filled in by the input handler
      seq_op.data  = '0;
      case (state)
         cam_bist_pkg::SEARCH_FULL: bist_expect = cam_bist_pkg::EXP_ALL;
         cam_bist_pkg::SEARCH_MASK: bist_expect = cam_bist_pkg::EXP_NONE_MATCH;
         default:                   bist_expect = cam_bist_pkg::EXP_NONE;
      endcase
   end

endmodule

/* hdl/cam_port_arbiter.sv */
// Arbiter for the single CAM port, BIST owns it while active and the host is served otherwise
`timescale 1ns/1ps

module cam_port_arbiter (
   input  logic                     bist_clk,
   input  logic                     rst_b,
   input  logic                     bist_active,
   input  cam_bist_pkg::cam_op_t    bist_op,
   input  logic                     host_req,
   input  cam_bist_pkg::host_req_t  host_cmd,
   output logic                     host_ack,
   output cam_bist_pkg::cam_match_t host_match,
   output cam_bist_pkg::cam_op_t    cam_op,
   input  cam_bist_pkg::cam_match_t cam_match,
   output cam_bist_pkg::cam_match_t bist_match
);

   // Host handshake states
   typedef enum logic [1:0] {
      H_IDLE,
      H_ISSUE,
      H_RESULT,
      H_ACK
   } host_state_t;

   host_state_t           hstate;
   cam_bist_pkg::cam_op_t host_op;

   // ----------------------------------------
   // Host four-phase FSM
   // ----------------------------------------

   always_ff @(posedge bist_clk) begin
      if (!rst_b) begin
         hstate <= H_IDLE;
      end else begin
         case (hstate)
            H_IDLE:   if (host_req && !bist_active) hstate <= H_ISSUE;
            // Lost the port to BIST, try again once it is done
            H_ISSUE:  hstate <= bist_active ? H_IDLE : H_RESULT;
            H_RESULT: hstate <= H_ACK;
            H_ACK:    if (!host_req) hstate <= H_IDLE;
            default:  hstate <= H_IDLE;
         endcase
      end
   end

   // Match vector of the host op returns one cycle after issue
   always_ff @(posedge bist_clk) begin
      if (hstate == H_RESULT) begin
         host_match <= cam_match;
      end
   end

   assign host_ack = (hstate == H_ACK);

   // ----------------------------------------
   // Port mux and match routing
   // ----------------------------------------

   // Host op is issued for one cycle only
   always_comb begin
      host_op.valid = (hstate == H_ISSUE);
      host_op.write = host_cmd.write;
      host_op.addr  = host_cmd.addr;
      host_op.data  = host_cmd.data;
   end

   assign cam_op     = bist_active ? bist_op : host_op;
   assign bist_match = bist_active ? cam_match : '0;

endmodule

/* hdl/cam_array.sv */
// Behavioral binary CAM, synchronous write and registered match vector on one shared port
`timescale 1ns/1ps
`include "cam_bist_macros.svh"

module cam_array (
   input  logic                     bist_clk,
   input  cam_bist_pkg::cam_op_t    cam_op,
   output cam_bist_pkg::cam_match_t match
);

   // Entry storage, undefined until written
   cam_bist_pkg::cam_data_t entries [`CAM_DEPTH];

   // Search result before the output register
   cam_bist_pkg::cam_match_t hit;

   // ----------------------------------------
   // Write
   // ----------------------------------------

   // Data lands on the edge the op is presented
   always_ff @(posedge bist_clk) begin
      if (cam_op.valid && cam_op.write) begin
         entries[cam_op.addr] <= cam_op.data;
      end
   end

   // ----------------------------------------
   // Search
   // ----------------------------------------

   // Full-width compare of the key against every entry
   always_comb begin
      for (int n = 0; n < `CAM_DEPTH; n++) begin
         hit[n] = (entries[n] == cam_op.data);
      end
   end

   // Result valid the cycle after the search
   // Cleared when no search is on the port
   always_ff @(posedge bist_clk) begin
      if (cam_op.valid && !cam_op.write) begin
         match <= hit;
      end else begin
         match <= '0;
      end
   end

endmodule

/* hdl/cam_match_checker.sv */
// BIST result checker, compares match vectors with the expectation and records the first failure
`timescale 1ns/1ps
`include "cam_bist_macros.svh"

module cam_match_checker (
   input  logic                     bist_clk,
   input  logic                     rst_b,
   input  logic                     bist_req,
   input  cam_bist_pkg::expect_t    bist_expect,
   input  cam_bist_pkg::cam_match_t bist_match,
   output logic                     fail,
   output cam_bist_pkg::cam_addr_t  fail_entry
);

   // Expectation aligned with the returning vector
   cam_bist_pkg::expect_t    exp_q;
   logic                     req_q;
   cam_bist_pkg::cam_match_t mismatch;
   cam_bist_pkg::cam_addr_t  low_idx;

   // Bits that differ from all-ones or all-zeros
   always_comb begin
      case (exp_q)
         cam_bist_pkg::EXP_ALL:        mismatch = ~bist_match;
         cam_bist_pkg::EXP_NONE_MATCH: mismatch = bist_match;
         default:                      mismatch = '0;
      endcase
   end

   // Lowest mismatching entry wins
   always_comb begin
      low_idx = '0;
      for (int i = `CAM_DEPTH-1; i >= 0; i--) begin
         if (mismatch[i]) low_idx = cam_bist_pkg::cam_addr_t'(i);
      end
   end

   always_ff @(posedge bist_clk) begin
      if (!rst_b) begin
         exp_q      <= cam_bist_pkg::EXP_NONE;
         req_q      <= 1'b0;
         fail       <= 1'b0;
         fail_entry <= '0;
      end else begin
         exp_q <= bist_expect;
         req_q <= bist_req;
         // New run starts with a clean record
         if (bist_req && !req_q) begin
            fail       <= 1'b0;
            fail_entry <= '0;
         end else if (!fail && (|mismatch)) begin
            fail       <= 1'b1;
            fail_entry <= low_idx;
         end
      end
   end

endmodule

/* hdl/cam_bist_top.sv */
// CAM BIST subsystem top, ties the sequencer, input handler, arbiter, CAM array and checker together
`timescale 1ns/1ps

module cam_bist_top (
   input  logic                     bist_clk,
   input  logic                     rst_b,
   input  logic                     bist_req,
   input  logic                     check_only,
   output logic                     bist_ack,
   output logic                     bist_active,
   input  logic                     host_req,
   input  cam_bist_pkg::host_req_t  host_cmd,
   output logic                     host_ack,
   output cam_bist_pkg::cam_match_t host_match,
   output logic                     fail,
   output cam_bist_pkg::cam_addr_t  fail_entry
);

   // ----------------------------------------
   // Internal nets
   // ----------------------------------------

   logic                     inv_data;
   logic                     mask_en;
   logic                     rotate;
   // Op skeleton from the sequencer
   cam_bist_pkg::cam_op_t    seq_op;
   // Completed BIST op with data
   cam_bist_pkg::cam_op_t    bist_op;
   cam_bist_pkg::expect_t    bist_expect;
   // Arbitrated port to the array
   cam_bist_pkg::cam_op_t    cam_op;
   cam_bist_pkg::cam_match_t cam_match;
   cam_bist_pkg::cam_match_t bist_match;

   cam_bist_sequencer u_sequencer (
      .bist_clk    (bist_clk),
      .rst_b       (rst_b),
      .bist_req    (bist_req),
      .check_only  (check_only),
      .bist_ack    (bist_ack),
      .bist_active (bist_active),
      .inv_data    (inv_data),
      .mask_en     (mask_en),
      .rotate      (rotate),
      .seq_op      (seq_op),
      .bist_expect (bist_expect)
   );

   cam_bist_inhandler u_inhandler (
      .bist_clk (bist_clk),
      .rst_b    (rst_b),
      .inv_data (inv_data),
      .mask_en  (mask_en),
      .rotate   (rotate),
      .seq_op   (seq_op),
      .bist_op  (bist_op)
   );

   cam_port_arbiter u_arbiter (
      .bist_clk    (bist_clk),
      .rst_b       (rst_b),
      .bist_active (bist_active),
      .bist_op     (bist_op),
      .host_req    (host_req),
      .host_cmd    (host_cmd),
      .host_ack    (host_ack),
      .host_match  (host_match),
      .cam_op      (cam_op),
      .cam_match   (cam_match),
      .bist_match  (bist_match)
   );

   cam_array u_array (
      .bist_clk (bist_clk),
      .cam_op   (cam_op),
      .match    (cam_match)
   );

   cam_match_checker u_checker (
      .bist_clk    (bist_clk),
      .rst_b       (rst_b),
      .bist_req    (bist_req),
      .bist_expect (bist_expect),
      .bist_match  (bist_match),
      .fail        (fail),
      .fail_entry  (fail_entry)
   );

endmodule

/* tb/cam_bist_tb.sv */
// Testbench for the CAM BIST subsystem, runs BIST and host traffic against cam_bist_top
`timescale 1ns/1ps
`include "cam_bist_macros.svh"

module cam_bist_tb;

   localparam int CLK_PERIOD      = 40;
   localparam int NUM_TESTS       = 6;
   localparam int CYCLES_PER_TEST = 400;

   logic                     bist_clk;
   logic                     rst_b;
   logic                     bist_req;
   logic                     check_only;
   logic                     bist_ack;
   logic                     bist_active;
   logic                     host_req;
   cam_bist_pkg::host_req_t  host_cmd;
   logic                     host_ack;
   cam_bist_pkg::cam_match_t host_match;
   logic                     fail;
   cam_bist_pkg::cam_addr_t  fail_entry;

   int                       errors;
   int                       tests_failed;
   int                       test_errors;
   int                       bist_ack_count;
   int                       acks_at_host_ack;
   int                       acks_before;
   integer                   seed;
   logic                     fail_start;
   cam_bist_pkg::cam_match_t match;
   cam_bist_pkg::cam_data_t  true_pat;
   cam_bist_pkg::cam_data_t  inv_pat;
   cam_bist_pkg::cam_data_t  rnd;
   cam_bist_pkg::cam_addr_t  bad_entry;

   cam_bist_top dut0 (
      .bist_clk    (bist_clk),
      .rst_b       (rst_b),
      .bist_req    (bist_req),
      .check_only  (check_only),
      .bist_ack    (bist_ack),
      .bist_active (bist_active),
      .host_req    (host_req),
      .host_cmd    (host_cmd),
      .host_ack    (host_ack),
      .host_match  (host_match),
      .fail        (fail),
      .fail_entry  (fail_entry)
   );

   // 40 ns clock
   always #(CLK_PERIOD/2) bist_clk = ~bist_clk;

   // Count bist_ack rises, snapshot the count when the host gets its ack
   always @(posedge bist_ack) bist_ack_count++;
   always @(posedge host_ack) acks_at_host_ack = bist_ack_count;

   // ----------------------------------------
   // Protocol assertions
   // ----------------------------------------

   // BIST ack only answers a held request
   assert property (@(posedge bist_clk) disable iff (!rst_b) $rose(bist_ack) |-> bist_req)
      else begin
         errors++;
         $display("FAILED %0t ns: bist_ack rose without bist_req", $time);
      end
   // Ack stays up while req is held, drops once req is gone
   assert property (@(posedge bist_clk) disable iff (!rst_b) bist_ack && bist_req |=> bist_ack)
      else begin
         errors++;
         $display("FAILED %0t ns: bist_ack dropped while bist_req held", $time);
      end
   assert property (@(posedge bist_clk) disable iff (!rst_b) bist_ack && !bist_req |=> !bist_ack)
      else begin
         errors++;
         $display("FAILED %0t ns: bist_ack stayed high after bist_req fell", $time);
      end
   assert property (@(posedge bist_clk) disable iff (!rst_b) bist_ack |-> !bist_active)
      else begin
         errors++;
         $display("FAILED %0t ns: bist_active high together with bist_ack", $time);
      end
   // Host is never served during a run
   assert property (@(posedge bist_clk) disable iff (!rst_b) !(host_ack && bist_active))
      else begin
         errors++;
         $display("FAILED %0t ns: host_ack while bist_active", $time);
      end
   assert property (@(posedge bist_clk) disable iff (!rst_b) $rose(host_ack) |-> host_req)
      else begin
         errors++;
         $display("FAILED %0t ns: host_ack rose without host_req", $time);
      end

   // ----------------------------------------
   // Helper tasks
   // ----------------------------------------

   task automatic compare_value(input logic [31:0] got, input logic [31:0] want,
                                input string what);
      assert (got === want) else begin
         errors++;
         $display("FAILED %0t ns: %s got %0h expected %0h", $time, what, got, want);
      end
   endtask

   // Four-phase host transfer, returns the match vector of a search
   task automatic host_access(input logic wr, input cam_bist_pkg::cam_addr_t addr,
                              input cam_bist_pkg::cam_data_t data,
                              output cam_bist_pkg::cam_match_t result);
      @(posedge bist_clk);
      host_cmd.write <= wr;
      host_cmd.addr  <= addr;
      host_cmd.data  <= data;
      host_req       <= 1'b1;
      do @(negedge bist_clk); while (!host_ack);
      result = host_match;
      @(posedge bist_clk);
      host_req <= 1'b0;
      do @(negedge bist_clk); while (host_ack);
   endtask

   // One BIST run, fail sampled in the first active cycle too
   task automatic run_bist(input logic chk, output logic fail_at_start);
      @(posedge bist_clk);
      check_only <= chk;
      bist_req   <= 1'b1;
      do @(negedge bist_clk); while (!bist_active);
      fail_at_start = fail;
      do @(negedge bist_clk); while (!bist_ack);
      @(posedge bist_clk);
      bist_req <= 1'b0;
      do @(negedge bist_clk); while (bist_ack);
   endtask

   task automatic finish_test(input int num, input string name);
      if (errors == test_errors) begin
         $display("Test %0d %s: ok", num, name);
      end else begin
         tests_failed++;
         $display("Test %0d %s: %0d check(s) failed", num, name, errors - test_errors);
      end
      test_errors = errors;
   endtask

   // ----------------------------------------
   // Watchdog
   // ----------------------------------------

   initial begin
      #(NUM_TESTS * CYCLES_PER_TEST * CLK_PERIOD);
      $display("Watchdog expired, the tests did not finish in time");
      $display("TEST RESULT: FAIL");
      $finish;
   end

   // ----------------------------------------
   // Test sequence
   // ----------------------------------------

   initial begin
      bist_clk       = 1'b0;
      rst_b          = 1'b0;
      bist_req       = 1'b0;
      check_only     = 1'b0;
      host_req       = 1'b0;
      host_cmd       = '0;
      errors         = 0;
      tests_failed   = 0;
      test_errors    = 0;
      bist_ack_count = 0;
      seed           = 32'h91be_1f95;
      // Pass data by the pattern rule, second pass is the complement
      true_pat = `CAM_BIST_PATTERN;
      inv_pat  = ~true_pat;

      repeat (3) @(posedge bist_clk);
      rst_b <= 1'b1;

      // Full run on a fresh array
      run_bist(1'b0, fail_start);
      compare_value(fail, 0, "fail after full run");
      finish_test(1, "full run");

      // Array now holds the inverted pattern
      host_access(1'b0, '0, inv_pat, match);
      compare_value(match, 8'hFF, "search for inverted pattern");
      do rnd = $random(seed); while (rnd == inv_pat);
      host_access(1'b0, '0, rnd, match);
      compare_value(match, 8'h00, "search for random key");
      finish_test(2, "host search after run");

      // One corrupted entry, caught by the true-pass full search
      bad_entry = $random(seed);
      do rnd = $random(seed); while (rnd == true_pat);
      for (int n = 0; n < `CAM_DEPTH; n++) begin
         host_access(1'b1, n, (n == bad_entry) ? rnd : true_pat, match);
      end
      run_bist(1'b1, fail_start);
      compare_value(fail, 1, "fail with corrupted entry");
      compare_value(fail_entry, bad_entry, "fail_entry with corrupted entry");
      finish_test(3, "check-only single fault");

      // Inverted data everywhere fails the true pass at entry 0
      for (int n = 0; n < `CAM_DEPTH; n++) begin
         host_access(1'b1, n, inv_pat, match);
      end
      run_bist(1'b1, fail_start);
      compare_value(fail, 1, "fail with inverted contents");
      compare_value(fail_entry, 0, "lowest failing entry");
      finish_test(4, "check-only lowest entry");

      // Host request held off by a run in progress
      acks_before = bist_ack_count;
      fork
         run_bist(1'b0, fail_start);
         begin
            do @(negedge bist_clk); while (!bist_active);
            host_access(1'b0, '0, inv_pat, match);
         end
      join
      compare_value(acks_at_host_ack, acks_before + 1, "bist_ack rises before host_ack");
      compare_value(match, 8'hFF, "deferred host search");
      finish_test(5, "host back-pressure");

      // Corrupt the array again, new request must clear the old fail
      host_access(1'b1, 3'd5, rnd, match);
      run_bist(1'b1, fail_start);
      compare_value(fail, 1, "fail before rerun");
      run_bist(1'b0, fail_start);
      compare_value(fail_start, 0, "fail cleared by new bist_req");
      compare_value(fail, 0, "fail after clean rerun");
      finish_test(6, "fail clear and rerun");

      $display("Tests run %0d, tests failed %0d, checks failed %0d",
               NUM_TESTS, tests_failed, errors);
      if (errors == 0) begin
         $display("TEST RESULT: PASS");
      end else begin
         $display("TEST RESULT: FAIL");
      end
      $finish;
   end

endmodule

/* src.f */
+incdir+hdl
hdl/cam_bist_pkg.sv
hdl/cam_bist_inhandler.sv
hdl/cam_bist_sequencer.sv
hdl/cam_port_arbiter.sv
hdl/cam_array.sv
hdl/cam_match_checker.sv
hdl/cam_bist_top.sv
tb/cam_bist_tb.sv
